// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bus_fabric_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wall

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/bus_fabric_tb.sv ====
`timescale 1ns/1ps

module bus_fabric_tb;

    typedef struct {
        string                tag;
        string                req;
        string                op;
        bus_pkg::addr_t       addr;
        bus_pkg::size_t       size;
        bus_pkg::data_t       wdata;
        bus_pkg::strb_t       strb;
        bus_pkg::data_t       exp_data;
        bus_pkg::resp_t       exp_resp;
    } txn_t;

    logic clock, rst_n;
    logic fetch_ar_valid, fetch_ar_ready, fetch_r_valid, fetch_r_ready;
    bus_pkg::addr_t fetch_ar_addr;
    bus_pkg::data_t fetch_r_data;
    bus_pkg::resp_t fetch_r_resp;
    logic lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
    bus_pkg::addr_t lsu_ar_addr;
    bus_pkg::size_t lsu_ar_size;
    bus_pkg::data_t lsu_r_data;
    bus_pkg::resp_t lsu_r_resp;
    logic lsu_w_valid, lsu_w_ready, lsu_b_valid, lsu_b_ready;
    bus_pkg::addr_t lsu_w_addr;
    bus_pkg::data_t lsu_w_data;
    bus_pkg::strb_t lsu_w_strb;
    bus_pkg::resp_t lsu_b_resp;
    logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
    bus_pkg::addr_t m_ar_addr;
    bus_pkg::size_t m_ar_size;
    bus_pkg::data_t m_r_data;
    bus_pkg::resp_t m_r_resp;
    logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
    bus_pkg::addr_t m_aw_addr;
    bus_pkg::data_t m_w_data;
    bus_pkg::strb_t m_w_strb;
    bus_pkg::resp_t m_b_resp;

    bus_pkg::data_t mem [bus_pkg::addr_t];
    bus_pkg::addr_t rd_q[$];
    bus_pkg::addr_t ar_log[$];
    bus_pkg::size_t size_log[$];
    txn_t           stim[$];
    bus_pkg::addr_t aw_addr_s;
    bus_pkg::data_t w_data_s;
    bus_pkg::strb_t w_strb_s;
    logic           have_aw, have_w, r_fire, b_fire;
    int             fetch_issued, fetch_done, lsu_issued, lsu_done;
    int             cycles, cycle_limit;
    bus_pkg::data_t last_tick;
    bit             have_tick;

    bus_fabric dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t exp, act);
        if (exp !== act) begin
            stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input bus_pkg::resp_t exp, act);
        if (exp !== act) begin
            stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input bus_pkg::addr_t exp, act);
        if (exp !== act) begin
            stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_size(input string name, input bus_pkg::size_t exp, act);
        if (exp !== act) begin
            stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    function automatic bus_pkg::data_t merge_strobe(input bus_pkg::data_t old_w, new_w,
                                                     input bus_pkg::strb_t strb);
        bus_pkg::data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic load_stim();
        int    fd;
        int    rc;
        string tag;
        string rest;
        txn_t  t;
        bus_pkg::addr_t a;
        bus_pkg::data_t d;
        fd = $fopen("bench/fabric_stim.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the stimulus file bench/fabric_stim.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag.getc(0) == "#") begin
                rc = $fgets(rest, fd);
            end else if (tag == "init") begin
                rc = $fscanf(fd, "%h %h", a, d);
                if (rc != 2) begin
                    stop_on_error("an init line of the stimulus file is incomplete");
                end
                mem[a] = d;
            end else begin
                t.tag = tag;
                rc = $fscanf(fd, "%s %s %h %h %h %h %h %h", t.req, t.op, t.addr, t.size,
                             t.wdata, t.strb, t.exp_data, t.exp_resp);
                if (rc != 8) begin
                    stop_on_error("a transaction line of the stimulus file is incomplete");
                end
                stim.push_back(t);
            end
        end
        $fclose(fd);
    endtask

    task automatic do_read(input bit lsu, input bus_pkg::addr_t a, input bus_pkg::size_t sz,
                           output bus_pkg::data_t d, output bus_pkg::resp_t r);
        bit got;
        got = 1'b0;
        @(posedge clock);
        if (lsu) begin
            lsu_ar_valid <= 1'b1;
            lsu_ar_addr  <= a;
            lsu_ar_size  <= sz;
        end else begin
            fetch_ar_valid <= 1'b1;
            fetch_ar_addr  <= a;
        end
        do @(negedge clock); while (!(lsu ? lsu_ar_ready : fetch_ar_ready));
        @(posedge clock);
        if (lsu) begin
            lsu_ar_valid <= 1'b0;
            lsu_issued++;
        end else begin
            fetch_ar_valid <= 1'b0;
            fetch_issued++;
        end
        while (!got) begin
            // random back-pressure on the response
            if (lsu) lsu_r_ready <= ($urandom % 3 != 0);
            else fetch_r_ready <= ($urandom % 3 != 0);
            @(negedge clock);
            if (lsu && lsu_r_valid && lsu_r_ready) begin
                d   = lsu_r_data;
                r   = lsu_r_resp;
                got = 1'b1;
            end else if (!lsu && fetch_r_valid && fetch_r_ready) begin
                d   = fetch_r_data;
                r   = fetch_r_resp;
                got = 1'b1;
            end
            @(posedge clock);
        end
        if (lsu) begin
            lsu_r_ready <= 1'b0;
            lsu_done++;
        end else begin
            fetch_r_ready <= 1'b0;
            fetch_done++;
        end
    endtask

    task automatic do_write(input bus_pkg::addr_t a, input bus_pkg::data_t d,
                            input bus_pkg::strb_t s, output bus_pkg::resp_t r);
        bit got;
        got = 1'b0;
        @(posedge clock);
        lsu_w_valid <= 1'b1;
        lsu_w_addr  <= a;
        lsu_w_data  <= d;
        lsu_w_strb  <= s;
        do @(negedge clock); while (!lsu_w_ready);
        @(posedge clock);
        lsu_w_valid <= 1'b0;
        lsu_issued++;
        while (!got) begin
            lsu_b_ready <= ($urandom % 3 != 0);
            @(negedge clock);
            if (lsu_b_valid && lsu_b_ready) begin
                r   = lsu_b_resp;
                got = 1'b1;
            end
            @(posedge clock);
        end
        lsu_b_ready <= 1'b0;
        lsu_done++;
    endtask

    task automatic run_txn(input txn_t t, input bit paired);
        int             base;
        bit             timer;
        bus_pkg::data_t d;
        bus_pkg::resp_t r;
        base  = ar_log.size();
        timer = (t.addr[31:16] == 16'h0200);
        if (t.op == "write") begin
            do_write(t.addr, t.wdata, t.strb, r);
            check_resp("lsu_b_resp", t.exp_resp, r);
        end else begin
            do_read(t.req == "lsu", t.addr, t.size, d, r);
            check_resp({t.req, "_r_resp"}, t.exp_resp, r);
            if (t.tag == "tick") begin
                if (have_tick && !(d > last_tick)) begin
                    stop_on_error("timer value did not increase between two reads");
                end
                last_tick = d;
                have_tick = 1'b1;
            end else begin
                check_data({t.req, "_r_data"}, t.exp_data, d);
            end
            if (timer && ar_log.size() != base) begin
                stop_on_error("a timer read appeared on the external read port");
            end
            if (!timer && !paired) begin
                check_addr("m_ar_addr", t.addr, ar_log[base]);
                check_size("m_ar_size", (t.req == "fetch") ? bus_pkg::WORD_SIZE : t.size,
                           size_log[base]);
            end
        end
    endtask

    // external memory samples handshakes at negedge and updates at posedge
    always @(negedge clock) begin
        r_fire = m_r_valid && m_r_ready;
        b_fire = m_b_valid && m_b_ready;
        if (m_ar_valid && m_ar_ready) begin
            rd_q.push_back(m_ar_addr);
            ar_log.push_back(m_ar_addr);
            size_log.push_back(m_ar_size);
        end
        if (m_aw_valid && m_aw_ready) begin
            aw_addr_s = m_aw_addr;
            have_aw   = 1'b1;
        end
        if (m_w_valid && m_w_ready) begin
            w_data_s = m_w_data;
            w_strb_s = m_w_strb;
            have_w   = 1'b1;
        end
        if (rst_n && fetch_r_valid && fetch_done == fetch_issued) begin
            stop_on_error("fetch response presented without a request");
        end
        if (rst_n && (lsu_r_valid || lsu_b_valid) && lsu_done == lsu_issued) begin
            stop_on_error("load/store response presented without a request");
        end
    end

    always @(posedge clock) begin
        m_ar_ready <= ($urandom % 2 != 0);
        m_aw_ready <= ($urandom % 2 != 0);
        m_w_ready  <= ($urandom % 2 != 0);
        if (r_fire) begin
            m_r_valid <= 1'b0;
        end else if (!m_r_valid && rd_q.size() > 0 && $urandom % 2) begin
            m_r_data  <= mem.exists(rd_q[0]) ? mem[rd_q[0]] : 32'd0;
            m_r_resp  <= bus_pkg::RESP_OKAY;
            m_r_valid <= 1'b1;
            void'(rd_q.pop_front());
        end
        if (b_fire) begin
            m_b_valid <= 1'b0;
        end else if (have_aw && have_w && !m_b_valid && $urandom % 2) begin
            mem[aw_addr_s] = merge_strobe(mem.exists(aw_addr_s) ? mem[aw_addr_s] : 32'd0,
                                          w_data_s, w_strb_s);
            have_aw = 1'b0;
            have_w  = 1'b0;
            m_b_resp  <= bus_pkg::RESP_OKAY;
            m_b_valid <= 1'b1;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, the transactions did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped");
        end
    end

    initial begin
        void'($urandom(32'h8c17037b));
        cycle_limit = 100000;
        cycles = 0;
        have_aw = 1'b0;
        have_w  = 1'b0;
        r_fire  = 1'b0;
        b_fire  = 1'b0;
        have_tick = 1'b0;
        rst_n <= 1'b0;
        fetch_ar_valid <= 1'b0;
        fetch_ar_addr  <= '0;
        fetch_r_ready  <= 1'b0;
        lsu_ar_valid   <= 1'b0;
        lsu_ar_addr    <= '0;
        lsu_ar_size    <= '0;
        lsu_r_ready    <= 1'b0;
        lsu_w_valid    <= 1'b0;
        lsu_w_addr     <= '0;
        lsu_w_data     <= '0;
        lsu_w_strb     <= '0;
        lsu_b_ready    <= 1'b0;
        m_ar_ready     <= 1'b0;
        m_r_valid      <= 1'b0;
        m_r_data       <= '0;
        m_r_resp       <= '0;
        m_aw_ready     <= 1'b0;
        m_w_ready      <= 1'b0;
        m_b_valid      <= 1'b0;
        m_b_resp       <= '0;
        load_stim();
        cycle_limit = 64 * stim.size() + 200;
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < stim.size(); i++) begin
            if (stim[i].tag == "pair") begin
                int base;
                base = ar_log.size();
                fork
                    run_txn(stim[i], 1'b1);
                    run_txn(stim[i+1], 1'b1);
                join
                // load/store wins the paired cycle
                check_addr("m_ar_addr", (stim[i].req == "lsu") ? stim[i].addr : stim[i+1].addr,
                           ar_log[base]);
                i++;
            end else begin
                run_txn(stim[i], 1'b0);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== bench/fabric_stim.txt ====
# init: addr data
# other lines: tag req op addr size wdata strb exp_data exp_resp (hex), tag txn/pair/tick
init 80000000 00000013
init 80000004 00100093
init 80000008 deadbeef
init 80000100 11223344
init 80000200 cafef00d
# fetch reads from preloaded memory
txn fetch read 80000000 2 0 0 00000013 0
txn fetch read 80000004 2 0 0 00100093 0
txn fetch read 80000008 2 0 0 deadbeef 0
# partial strobe write then read back
txn lsu write 80000100 2 aabbccdd 5 0 0
txn lsu read 80000100 2 0 0 11bb33dd 0
txn lsu write 80000300 2 01020304 f 0 0
txn lsu read 80000300 2 0 0 01020304 0
# same-cycle requests, load/store first
pair fetch read 80000004 2 0 0 00100093 0
pair lsu read 80000200 2 0 0 cafef00d 0
# timer region
tick lsu read 0200bff8 2 0 0 0 0
tick lsu read 0200bff8 2 0 0 0 0
txn lsu read 02000010 2 0 0 00000000 2
txn lsu write 02000004 2 12345678 f 0 2
txn fetch read 80000100 2 0 0 11bb33dd 0
pair lsu read 80000008 2 0 0 deadbeef 0
pair fetch read 80000000 2 0 0 00000013 0

// ==== source/bus_fabric.sv ====
`timescale 1ns/1ps

module bus_fabric (
    input  logic           clock,
    input  logic           rst_n,

    input  logic           fetch_ar_valid,
    output logic           fetch_ar_ready,
    input  bus_pkg::addr_t fetch_ar_addr,
    output logic           fetch_r_valid,
    input  logic           fetch_r_ready,
    output bus_pkg::data_t fetch_r_data,
    output bus_pkg::resp_t fetch_r_resp,

    input  logic           lsu_ar_valid,
    output logic           lsu_ar_ready,
    input  bus_pkg::addr_t lsu_ar_addr,
    input  bus_pkg::size_t lsu_ar_size,
    output logic           lsu_r_valid,
    input  logic           lsu_r_ready,
    output bus_pkg::data_t lsu_r_data,
    output bus_pkg::resp_t lsu_r_resp,

    input  logic           lsu_w_valid,
    output logic           lsu_w_ready,
    input  bus_pkg::addr_t lsu_w_addr,
    input  bus_pkg::data_t lsu_w_data,
    input  bus_pkg::strb_t lsu_w_strb,
    output logic           lsu_b_valid,
    input  logic           lsu_b_ready,
    output bus_pkg::resp_t lsu_b_resp,

    output logic           m_ar_valid,
    input  logic           m_ar_ready,
    output bus_pkg::addr_t m_ar_addr,
    output bus_pkg::size_t m_ar_size,
    input  logic           m_r_valid,
    output logic           m_r_ready,
    input  bus_pkg::data_t m_r_data,
    input  bus_pkg::resp_t m_r_resp,
    output logic           m_aw_valid,
    input  logic           m_aw_ready,
    output bus_pkg::addr_t m_aw_addr,
    output logic           m_w_valid,
    input  logic           m_w_ready,
    output bus_pkg::data_t m_w_data,
    output bus_pkg::strb_t m_w_strb,
    input  logic           m_b_valid,
    output logic           m_b_ready,
    input  bus_pkg::resp_t m_b_resp
);

    logic                 ext_ar_valid;
    logic                 ext_ar_ready;
    bus_pkg::ar_payload_t ext_ar_data;
    logic                 ext_r_valid;
    logic                 ext_r_ready;
    bus_pkg::r_payload_t  ext_r_data;
    bus_pkg::ar_payload_t m_ar_data;
    bus_pkg::r_payload_t  m_r_pkt;

    logic                 t_ar_valid;
    logic                 t_ar_ready;
    bus_pkg::addr_t       t_ar_addr;
    logic                 t_r_valid;
    logic                 t_r_ready;
    bus_pkg::data_t       t_r_data;
    bus_pkg::resp_t       t_r_resp;

    assign m_ar_addr    = m_ar_data.addr;
    assign m_ar_size    = m_ar_data.size;
    assign m_r_pkt.data = m_r_data;
    assign m_r_pkt.resp = m_r_resp;

    read_arbiter read_arbiter_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .fetch_ar_valid (fetch_ar_valid),
        .fetch_ar_ready (fetch_ar_ready),
        .fetch_ar_addr  (fetch_ar_addr),
        .fetch_r_valid  (fetch_r_valid),
        .fetch_r_ready  (fetch_r_ready),
        .fetch_r_data   (fetch_r_data),
        .fetch_r_resp   (fetch_r_resp),
        .lsu_ar_valid   (lsu_ar_valid),
        .lsu_ar_ready   (lsu_ar_ready),
        .lsu_ar_addr    (lsu_ar_addr),
        .lsu_ar_size    (lsu_ar_size),
        .lsu_r_valid    (lsu_r_valid),
        .lsu_r_ready    (lsu_r_ready),
        .lsu_r_data     (lsu_r_data),
        .lsu_r_resp     (lsu_r_resp),
        .ext_ar_valid   (ext_ar_valid),
        .ext_ar_ready   (ext_ar_ready),
        .ext_ar_data    (ext_ar_data),
        .ext_r_valid    (ext_r_valid),
        .ext_r_ready    (ext_r_ready),
        .ext_r_data     (ext_r_data),
        .t_ar_valid     (t_ar_valid),
        .t_ar_ready     (t_ar_ready),
        .t_ar_addr      (t_ar_addr),
        .t_r_valid      (t_r_valid),
        .t_r_ready      (t_r_ready),
        .t_r_data       (t_r_data),
        .t_r_resp       (t_r_resp)
    );

    // registered boundary toward the external port
    req_slice #(.payload_t(bus_pkg::ar_payload_t)) ar_slice_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (ext_ar_valid),
        .in_ready  (ext_ar_ready),
        .in_data   (ext_ar_data),
        .out_valid (m_ar_valid),
        .out_ready (m_ar_ready),
        .out_data  (m_ar_data)
    );

    req_slice #(.payload_t(bus_pkg::r_payload_t)) r_slice_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (m_r_valid),
        .in_ready  (m_r_ready),
        .in_data   (m_r_pkt),
        .out_valid (ext_r_valid),
        .out_ready (ext_r_ready),
        .out_data  (ext_r_data)
    );

    write_channel write_channel_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .lsu_w_valid (lsu_w_valid),
        .lsu_w_ready (lsu_w_ready),
        .lsu_w_addr  (lsu_w_addr),
        .lsu_w_data  (lsu_w_data),
        .lsu_w_strb  (lsu_w_strb),
        .lsu_b_valid (lsu_b_valid),
        .lsu_b_ready (lsu_b_ready),
        .lsu_b_resp  (lsu_b_resp),
        .m_aw_valid  (m_aw_valid),
        .m_aw_ready  (m_aw_ready),
        .m_aw_addr   (m_aw_addr),
        .m_w_valid   (m_w_valid),
        .m_w_ready   (m_w_ready),
        .m_w_data    (m_w_data),
        .m_w_strb    (m_w_strb),
        .m_b_valid   (m_b_valid),
        .m_b_ready   (m_b_ready),
        .m_b_resp    (m_b_resp)
    );

    clint_timer clint_timer_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .t_ar_valid (t_ar_valid),
        .t_ar_ready (t_ar_ready),
        .t_ar_addr  (t_ar_addr),
        .t_r_valid  (t_r_valid),
        .t_r_ready  (t_r_ready),
        .t_r_data   (t_r_data),
        .t_r_resp   (t_r_resp)
    );

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // single-beat read request
    typedef struct packed {
        addr_t addr;
        size_t size;
    } ar_payload_t;

    // single-beat read response
    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_payload_t;

    // timer region, 64 KiB
    localparam addr_t CLINT_BASE = 32'h0200_0000;
    localparam addr_t CLINT_MASK = 32'hFFFF_0000;

    localparam logic [15:0] MTIME_LO_OFS = 16'hBFF8;
    localparam logic [15:0] MTIME_HI_OFS = 16'hBFFC;

    // every fetch is one 32-bit word
    localparam size_t WORD_SIZE = 3'd2;

    function automatic logic is_clint(input addr_t addr);
        return (addr & CLINT_MASK) == CLINT_BASE;
    endfunction

endpackage

// ==== source/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           t_ar_valid,
    output logic           t_ar_ready,
    input  bus_pkg::addr_t t_ar_addr,
    output logic           t_r_valid,
    input  logic           t_r_ready,
    output bus_pkg::data_t t_r_data,
    output bus_pkg::resp_t t_r_resp
);

    logic [63:0] mtime;
    logic [15:0] ofs;
    logic        ar_hs;

    // one read at a time, next one once the response is taken
    assign t_ar_ready = !t_r_valid;
    assign ofs        = t_ar_addr[15:0];
    assign ar_hs      = t_ar_valid && t_ar_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mtime     <= 64'd0;
            t_r_valid <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar_hs) begin
                t_r_valid <= 1'b1;
            end else if (t_r_ready) begin
                t_r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ar_hs) begin
            case (ofs)
                bus_pkg::MTIME_LO_OFS: begin
                    t_r_data <= mtime[31:0];
                    t_r_resp <= bus_pkg::RESP_OKAY;
                end
                bus_pkg::MTIME_HI_OFS: begin
                    t_r_data <= mtime[63:32];
                    t_r_resp <= bus_pkg::RESP_OKAY;
                end
                default: begin
                    // unmapped offset in timer region
                    t_r_data <= 32'd0;
                    t_r_resp <= bus_pkg::RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

// ==== source/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
    input  logic                 clock,
    input  logic                 rst_n,

    input  logic                 fetch_ar_valid,
    output logic                 fetch_ar_ready,
    input  bus_pkg::addr_t       fetch_ar_addr,
    output logic                 fetch_r_valid,
    input  logic                 fetch_r_ready,
    output bus_pkg::data_t       fetch_r_data,
    output bus_pkg::resp_t       fetch_r_resp,

    input  logic                 lsu_ar_valid,
    output logic                 lsu_ar_ready,
    input  bus_pkg::addr_t       lsu_ar_addr,
    input  bus_pkg::size_t       lsu_ar_size,
    output logic                 lsu_r_valid,
    input  logic                 lsu_r_ready,
    output bus_pkg::data_t       lsu_r_data,
    output bus_pkg::resp_t       lsu_r_resp,

    output logic                 ext_ar_valid,
    input  logic                 ext_ar_ready,
    output bus_pkg::ar_payload_t ext_ar_data,
    input  logic                 ext_r_valid,
    output logic                 ext_r_ready,
    input  bus_pkg::r_payload_t  ext_r_data,

    output logic                 t_ar_valid,
    input  logic                 t_ar_ready,
    output bus_pkg::addr_t       t_ar_addr,
    input  logic                 t_r_valid,
    output logic                 t_r_ready,
    input  bus_pkg::data_t       t_r_data,
    input  bus_pkg::resp_t       t_r_resp
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_FETCH,
        GNT_LSU
    } gnt_t;

    gnt_t           gnt;
    logic           ar_done;
    logic           to_timer;
    bus_pkg::addr_t gnt_addr;
    logic           gnt_ar_valid;
    logic           tgt_ar_ready;
    logic           tgt_r_valid;
    logic           own_r_ready;
    bus_pkg::data_t rsp_data;
    bus_pkg::resp_t rsp_resp;
    logic           ar_hs;
    logic           r_hs;

    // request side, routed by the latched target flag
    assign gnt_addr     = (gnt == GNT_LSU) ? lsu_ar_addr : fetch_ar_addr;
    assign gnt_ar_valid = !ar_done && (((gnt == GNT_LSU) && lsu_ar_valid) ||
                                       ((gnt == GNT_FETCH) && fetch_ar_valid));
    assign tgt_ar_ready = to_timer ? t_ar_ready : ext_ar_ready;

    assign ext_ar_valid     = gnt_ar_valid && !to_timer;
    assign ext_ar_data.addr = gnt_addr;
    assign ext_ar_data.size = (gnt == GNT_LSU) ? lsu_ar_size : bus_pkg::WORD_SIZE;
    assign t_ar_valid       = gnt_ar_valid && to_timer;
    assign t_ar_addr        = gnt_addr;

    assign fetch_ar_ready = (gnt == GNT_FETCH) && !ar_done && tgt_ar_ready;
    assign lsu_ar_ready   = (gnt == GNT_LSU) && !ar_done && tgt_ar_ready;

    // response side, only the owner sees it
    assign tgt_r_valid = ar_done && (to_timer ? t_r_valid : ext_r_valid);
    assign rsp_data    = to_timer ? t_r_data : ext_r_data.data;
    assign rsp_resp    = to_timer ? t_r_resp : ext_r_data.resp;
    assign own_r_ready = (gnt == GNT_LSU)   ? lsu_r_ready :
                         (gnt == GNT_FETCH) ? fetch_r_ready : 1'b0;

    assign fetch_r_valid = (gnt == GNT_FETCH) && tgt_r_valid;
    assign fetch_r_data  = rsp_data;
    assign fetch_r_resp  = rsp_resp;
    assign lsu_r_valid   = (gnt == GNT_LSU) && tgt_r_valid;
    assign lsu_r_data    = rsp_data;
    assign lsu_r_resp    = rsp_resp;

    assign ext_r_ready = ar_done && !to_timer && own_r_ready;
    assign t_r_ready   = ar_done && to_timer && own_r_ready;

    assign ar_hs = gnt_ar_valid && tgt_ar_ready;
    assign r_hs  = tgt_r_valid && own_r_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            gnt      <= GNT_IDLE;
            ar_done  <= 1'b0;
            to_timer <= 1'b0;
        end else if (gnt == GNT_IDLE) begin
            ar_done <= 1'b0;
            // lsu wins over fetch
            if (lsu_ar_valid) begin
                gnt      <= GNT_LSU;
                to_timer <= bus_pkg::is_clint(lsu_ar_addr);
            end else if (fetch_ar_valid) begin
                gnt      <= GNT_FETCH;
                to_timer <= bus_pkg::is_clint(fetch_ar_addr);
            end
        end else begin
            if (ar_hs) begin
                ar_done <= 1'b1;
            end
            if (r_hs) begin
                gnt     <= GNT_IDLE;
                ar_done <= 1'b0;
            end
        end
    end

endmodule

// ==== source/req_slice.sv ====
`timescale 1ns/1ps

module req_slice #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t   entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // registered on both sides, no path from out_ready to in_ready
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entry[wr_ptr] <= in_data;
        end
    end

endmodule

// ==== source/write_channel.sv ====
`timescale 1ns/1ps

module write_channel (
    input  logic           clock,
    input  logic           rst_n,

    input  logic           lsu_w_valid,
    output logic           lsu_w_ready,
    input  bus_pkg::addr_t lsu_w_addr,
    input  bus_pkg::data_t lsu_w_data,
    input  bus_pkg::strb_t lsu_w_strb,
    output logic           lsu_b_valid,
    input  logic           lsu_b_ready,
    output bus_pkg::resp_t lsu_b_resp,

    output logic           m_aw_valid,
    input  logic           m_aw_ready,
    output bus_pkg::addr_t m_aw_addr,
    output logic           m_w_valid,
    input  logic           m_w_ready,
    output bus_pkg::data_t m_w_data,
    output bus_pkg::strb_t m_w_strb,
    input  logic           m_b_valid,
    output logic           m_b_ready,
    input  bus_pkg::resp_t m_b_resp
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_RESP
    } wr_state_t;

    wr_state_t      state;
    logic           aw_pend;
    logic           w_pend;
    bus_pkg::addr_t addr_q;
    bus_pkg::data_t data_q;
    bus_pkg::strb_t strb_q;
    bus_pkg::resp_t resp_q;

    assign lsu_w_ready = (state == WR_IDLE);
    assign lsu_b_valid = (state == WR_RESP);
    assign lsu_b_resp  = resp_q;

    assign m_aw_valid = aw_pend;
    assign m_aw_addr  = addr_q;
    assign m_w_valid  = w_pend;
    assign m_w_data   = data_q;
    assign m_w_strb   = strb_q;
    // response only after both address and data are out
    assign m_b_ready  = (state == WR_SEND) && !aw_pend && !w_pend;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= WR_IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (lsu_w_valid) begin
                        if (bus_pkg::is_clint(lsu_w_addr)) begin
                            // timer is read-only, refuse locally
                            state <= WR_RESP;
                        end else begin
                            state   <= WR_SEND;
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                        end
                    end
                end
                WR_SEND: begin
                    if (m_aw_ready) begin
                        aw_pend <= 1'b0;
                    end
                    if (m_w_ready) begin
                        w_pend <= 1'b0;
                    end
                    if (m_b_valid && m_b_ready) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (lsu_b_ready) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (lsu_w_valid && lsu_w_ready) begin
            addr_q <= lsu_w_addr;
            data_q <= lsu_w_data;
            strb_q <= lsu_w_strb;
            resp_q <= bus_pkg::RESP_SLVERR;
        end else if (m_b_valid && m_b_ready) begin
            resp_q <= m_b_resp;
        end
    end

endmodule

// ==== sources.f ====
source/bus_pkg.sv
source/req_slice.sv
source/read_arbiter.sv
source/write_channel.sv
source/clint_timer.sv
source/bus_fabric.sv
bench/bus_fabric_tb.sv
